// File: cpu_mmu_top.f
verilog/nd_addr_pkg.sv
verilog/nd_pte_pkg.sv
verilog/mmu_page_table.sv
verilog/mmu_request_stage.sv
verilog/mmu_translate_stage.sv
verilog/cpu_mmu_top.sv
verification/cpu_mmu_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the MMU testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module cpu_mmu_top_tb -f cpu_mmu_top.f -o sim_mmu \
  || { echo "build failed"; exit 1; }
out="$(./obj_dir/sim_mmu 2>&1)"
echo "$out"
echo "$out" | grep -qx "TEST RESULT: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: verification/cpu_mmu_top_tb.sv
// Testbench for the CPU MMU path driven from patterns under random response stalls
`timescale 1ns/1ps

module cpu_mmu_top_tb;

  localparam string PATTERN_FILE = "verification/mmu_patterns.txt";

  logic                sysclk = 1'b0;
  logic                rst;
  logic                req_valid;
  logic                req_ready;
  nd_addr_pkg::vaddr_t req_vaddr;
  logic                req_write;
  logic                poni;
  logic                pt_load;
  nd_addr_pkg::page_t  pt_index;
  nd_pte_pkg::pte_t    pt_entry;
  logic                rsp_valid;
  logic                rsp_ready;
  nd_addr_pkg::paddr_t rsp_paddr;
  nd_pte_pkg::fault_t  rsp_fault;

  nd_addr_pkg::paddr_t exp_paddr_q[$];    // Scoreboard with one entry per accepted request
  nd_pte_pkg::fault_t  exp_fault_q[$];
  string               lines[$];          // Command lines of the pattern file
  int                  cycle_count;
  int                  cycle_limit;

  cpu_mmu_top uut (
    .sysclk   (sysclk),
    .rst      (rst),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .req_vaddr(req_vaddr),
    .req_write(req_write),
    .poni     (poni),
    .pt_load  (pt_load),
    .pt_index (pt_index),
    .pt_entry (pt_entry),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .rsp_paddr(rsp_paddr),
    .rsp_fault(rsp_fault)
  );

  initial begin
    sysclk = 1'b0;
    forever #10 sysclk = ~sysclk;         // 20 ns period
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_paddr(input nd_addr_pkg::paddr_t exp, input nd_addr_pkg::paddr_t act);
    if (act !== exp) begin
      $display("ERROR time=%0t signal=rsp_paddr expected=%06h actual=%06h", $time, exp, act);
      abort_run("wrong physical address");
    end
  endtask

  task automatic check_fault(input nd_pte_pkg::fault_t exp, input nd_pte_pkg::fault_t act);
    if (act !== exp) begin
      $display("ERROR time=%0t signal=rsp_fault expected=%0d actual=%0d", $time, exp, act);
      abort_run("wrong fault code");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
      abort_run("wrong handshake level");
    end
  endtask

  // Falling edge with default drives and a random response stall
  task automatic begin_cycle();
    @(negedge sysclk);
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      abort_run($sformatf("timeout, no progress after %0d cycles", cycle_count));
    end
    req_valid = 1'b0;
    pt_load   = 1'b0;
    rsp_ready = ($urandom % 3) != 0;      // Low about a third of the time
  endtask

  // Response taken at the coming rising edge is checked here
  task automatic end_cycle();
    nd_addr_pkg::paddr_t exp_pa;
    nd_pte_pkg::fault_t  exp_ft;
    #1;                                   // Combinational outputs settled
    if (rsp_valid && rsp_ready) begin
      if (exp_paddr_q.size() == 0) begin
        abort_run($sformatf("unexpected response at %0t with no request outstanding", $time));
      end
      exp_pa = exp_paddr_q.pop_front();
      exp_ft = exp_fault_q.pop_front();
      if (exp_ft == nd_pte_pkg::FAULT_NONE) begin
        check_paddr(exp_pa, rsp_paddr);   // Address only valid without fault
      end
      check_fault(exp_ft, rsp_fault);
    end
  endtask

  task automatic send_request(input nd_addr_pkg::vaddr_t va, input logic wr, input logic pn,
                              input nd_addr_pkg::paddr_t pa, input nd_pte_pkg::fault_t ft);
    bit accepted;
    accepted = 1'b0;
    if ($urandom % 4 == 0) begin
      repeat ($urandom % 3 + 1) begin     // Idle gap now and then
        begin_cycle();
        end_cycle();
      end
    end
    while (!accepted) begin
      begin_cycle();
      req_valid = 1'b1;                   // Held until req_ready
      req_vaddr = va;
      req_write = wr;
      poni      = pn;
      end_cycle();
      if (req_ready) begin
        exp_paddr_q.push_back(pa);
        exp_fault_q.push_back(ft);
        accepted = 1'b1;
      end
    end
  endtask

  task automatic drain();
    while (exp_paddr_q.size() != 0) begin
      begin_cycle();
      end_cycle();
    end
  endtask

  task automatic load_entry(input nd_addr_pkg::page_t idx, input nd_pte_pkg::pte_t ent);
    drain();                              // Nothing in flight during a load
    begin_cycle();
    pt_load  = 1'b1;
    pt_index = idx;
    pt_entry = ent;
    end_cycle();
  endtask

  task automatic read_patterns();
    int    fd;
    string line;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      abort_run({"cannot open pattern file ", PATTERN_FILE});
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
        lines.push_back(line);            // Comments and blank lines skipped
      end
    end
    $fclose(fd);
  endtask

  task automatic run_line(input string line);
    logic [31:0] f1, f2, f3, f4, f5;
    int          n;
    case (line.getc(0))
      "L": begin
        n = $sscanf(line, "L %h %h", f1, f2);
        if (n != 2) begin
          abort_run({"malformed load line: ", line});
        end
        load_entry(f1[nd_addr_pkg::PAGE_W-1:0], f2[nd_pte_pkg::PTE_W-1:0]);
      end
      "R": begin
        n = $sscanf(line, "R %h %h %h %h %h", f1, f2, f3, f4, f5);
        if (n != 5) begin
          abort_run({"malformed request line: ", line});
        end
        send_request(f1[nd_addr_pkg::VADDR_W-1:0], f2[0], f3[0],
                     f4[nd_addr_pkg::PADDR_W-1:0], f5[nd_pte_pkg::FAULT_W-1:0]);
      end
      "D": drain();
      default: abort_run({"unknown pattern command: ", line});
    endcase
  endtask

  initial begin
    void'($urandom(9));                   // Fixed random sequence
    rst         = 1'b1;
    req_valid   = 1'b0;
    req_vaddr   = '0;
    req_write   = 1'b0;
    poni        = 1'b0;
    pt_load     = 1'b0;
    pt_index    = '0;
    pt_entry    = '0;
    rsp_ready   = 1'b0;
    cycle_count = 0;
    read_patterns();
    cycle_limit = 20 * lines.size() + 100;
    repeat (4) begin                      // Reset held 4 cycles
      @(negedge sysclk);
      check_flag("rsp_valid", 1'b0, rsp_valid);
      check_flag("req_ready", 1'b1, req_ready);
    end
    rst = 1'b0;
    begin_cycle();
    end_cycle();
    check_flag("rsp_valid", 1'b0, rsp_valid); // First cycle out of reset
    check_flag("req_ready", 1'b1, req_ready);
    foreach (lines[i]) begin
      run_line(lines[i]);
    end
    drain();
    repeat (4) begin                      // Quiet tail where a stray response would show
      begin_cycle();
      end_cycle();
    end
    check_flag("rsp_valid", 1'b0, rsp_valid); // Nothing left behind
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: verification/mmu_patterns.txt
# Columns: L index entry | R vaddr write poni exp_paddr exp_fault | D (drain)
# All hex; write and poni 0/1; fault 0 none, 1 read, 2 write; paddr unchecked on fault
R 0000 0 0 000000 0
R 1456 1 0 001456 0
R FC01 0 0 00fc01 0
R 8123 1 0 008123 0
R 07FF 0 0 0007ff 0
D
# Table load, WPM bit 15, RPM bit 14, PPN 13:0
L 05 C123
L 0A 4ABC
L 3F 8FFF
L 00 3FFF
L 01 C000
L 20 FFFF
# Paging on, allowed accesses
R 1456 0 1 048c56 0
R 1456 1 1 048c56 0
R 29FF 0 1 2af1ff 0
R FC01 1 1 3ffc01 0
R 07FF 0 1 0003ff 0
R 07FF 1 1 0003ff 0
R 8123 0 1 fffd23 0
R 8123 1 1 fffd23 0
# Permission faults
R 29FF 1 1 000000 2
R FC01 0 1 000000 1
R 0000 0 1 000000 1
R 03FF 1 1 000000 2
# Paging off ignores the table
R 0000 1 0 000000 0
R 03FF 0 0 0003ff 0
R 29FF 1 0 0029ff 0
R FC01 0 0 00fc01 0
# Mixed modes back to back
R 1400 0 1 048c00 0
R 1400 0 0 001400 0
R 2800 1 1 000000 2
R 2800 1 0 002800 0
R 83FF 1 1 ffffff 0
R FFFF 1 1 3fffff 0
R FFFF 0 1 000000 1
R FFFF 0 0 00ffff 0
D
# Reload two entries with swapped permits
L 05 4222
L 0A 8001
R 1456 0 1 088856 0
R 1456 1 1 000000 2
R 17FF 0 1 088bff 0
R 29FF 1 1 0005ff 0
R 29FF 0 1 000000 1
R 8123 0 1 fffd23 0
R 1456 0 0 001456 0
R 07FF 1 1 0003ff 0
D

// File: verilog/cpu_mmu_top.sv
// CPU MMU top level, two-stage address translation with page table
`timescale 1ns/1ps

module cpu_mmu_top (
  input  logic                sysclk,     // System clock
  input  logic                rst,        // Sync reset, active high

  // Request side
  input  logic                req_valid,
  output logic                req_ready,
  input  nd_addr_pkg::vaddr_t req_vaddr,  // Logical address
  input  logic                req_write,  // 1 = write
  input  logic                poni,       // Paging on

  // Page table load, stands in for IDB
  input  logic                pt_load,
  input  nd_addr_pkg::page_t  pt_index,
  input  nd_pte_pkg::pte_t    pt_entry,

  // Response side
  output logic                rsp_valid,
  input  logic                rsp_ready,
  output nd_addr_pkg::paddr_t rsp_paddr,  // Physical address
  output nd_pte_pkg::fault_t  rsp_fault   // Fault code
);

  // Page table read path
  logic                 rd_en;
  nd_addr_pkg::page_t   rd_page;
  nd_pte_pkg::pte_t     rd_entry;

  // Stage link
  logic                 s1_valid;
  logic                 s1_ready;
  nd_addr_pkg::page_t   s1_page;
  nd_addr_pkg::offset_t s1_offset;
  logic                 s1_write;
  logic                 s1_poni;

  mmu_request_stage u_req (
    .sysclk   (sysclk),
    .rst      (rst),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .req_vaddr(req_vaddr),
    .req_write(req_write),
    .poni     (poni),
    .rd_en    (rd_en),
    .rd_page  (rd_page),
    .s1_valid (s1_valid),
    .s1_ready (s1_ready),
    .s1_page  (s1_page),
    .s1_offset(s1_offset),
    .s1_write (s1_write),
    .s1_poni  (s1_poni)
  );

  mmu_page_table u_pt (
    .sysclk  (sysclk),
    .pt_load (pt_load),
    .pt_index(pt_index),
    .pt_entry(pt_entry),
    .rd_en   (rd_en),
    .rd_page (rd_page),
    .rd_entry(rd_entry)             // Aligned with the held request
  );

  mmu_translate_stage u_xlt (
    .sysclk   (sysclk),
    .rst      (rst),
    .s1_valid (s1_valid),
    .s1_ready (s1_ready),
    .s1_page  (s1_page),
    .s1_offset(s1_offset),
    .s1_write (s1_write),
    .s1_poni  (s1_poni),
    .rd_entry (rd_entry),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .rsp_paddr(rsp_paddr),
    .rsp_fault(rsp_fault)
  );

endmodule

// File: verilog/mmu_page_table.sv
// MMU page table, 64 entries with a load port and a registered read port
`timescale 1ns/1ps

module mmu_page_table (
  input  logic               sysclk,    // System clock
  input  logic               pt_load,   // Load strobe, IDB side
  input  nd_addr_pkg::page_t pt_index,  // Entry to load
  input  nd_pte_pkg::pte_t   pt_entry,  // New entry word
  input  logic               rd_en,     // Read strobe from request stage
  input  nd_addr_pkg::page_t rd_page,   // Logical page to look up
  output nd_pte_pkg::pte_t   rd_entry   // Entry, one cycle after rd_en
);

  // Mapping RAM, undefined until loaded
  nd_pte_pkg::pte_t pt_mem [nd_addr_pkg::PT_DEPTH];

  // Load port
  always_ff @(posedge sysclk) begin
    if (pt_load) begin
      pt_mem[pt_index] <= pt_entry;     // Written on the load edge
    end
  end

  // Read port, old entry on a same-edge collision
  always_ff @(posedge sysclk) begin
    if (rd_en) begin
      rd_entry <= pt_mem[rd_page];      // Holds while rd_en is low
    end
  end

endmodule

// File: verilog/mmu_request_stage.sv
// MMU request stage, accepts requests and starts the page table lookup
`timescale 1ns/1ps

module mmu_request_stage (
  input  logic                 sysclk,     // System clock
  input  logic                 rst,        // Sync reset, active high
  input  logic                 req_valid,  // Request present
  output logic                 req_ready,  // Stage can take a request
  input  nd_addr_pkg::vaddr_t  req_vaddr,  // Logical address
  input  logic                 req_write,  // 1 = write, 0 = read
  input  logic                 poni,       // Paging on for this request
  output logic                 rd_en,      // Page table read strobe
  output nd_addr_pkg::page_t   rd_page,    // Page table index
  output logic                 s1_valid,   // Item held for translate stage
  input  logic                 s1_ready,   // Translate stage can take it
  output nd_addr_pkg::page_t   s1_page,    // Held logical page
  output nd_addr_pkg::offset_t s1_offset,  // Held word offset
  output logic                 s1_write,   // Held write flag
  output logic                 s1_poni     // Held paging mode
);

  logic accept;                            // Request taken this edge

  nd_addr_pkg::page_t   req_page;
  nd_addr_pkg::offset_t req_offset;

  // Address split, page above offset
  assign req_page   = req_vaddr[nd_addr_pkg::VADDR_W-1:nd_addr_pkg::OFFSET_W];
  assign req_offset = req_vaddr[nd_addr_pkg::OFFSET_W-1:0];

  assign req_ready = !s1_valid || s1_ready; // Empty or item leaving
  assign accept    = req_valid && req_ready;

  // Lookup starts with the accept, entry lines up with the held item
  assign rd_en   = accept;
  assign rd_page = req_page;

  always_ff @(posedge sysclk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else if (accept) begin
      s1_valid <= 1'b1;                    // New item replaces the old
    end else if (s1_ready) begin
      s1_valid <= 1'b0;                    // Item left, nothing new
    end
  end

  // Payload, loaded only on accept
  always_ff @(posedge sysclk) begin
    if (accept) begin
      s1_page   <= req_page;
      s1_offset <= req_offset;
      s1_write  <= req_write;
      s1_poni   <= poni;                   // Mode travels with the item
    end
  end

endmodule

// File: verilog/mmu_translate_stage.sv
// MMU translate stage, builds the physical address and checks permits
`timescale 1ns/1ps

module mmu_translate_stage (
  input  logic                 sysclk,     // System clock
  input  logic                 rst,        // Sync reset, active high
  input  logic                 s1_valid,   // Item from request stage
  output logic                 s1_ready,   // Response register free
  input  nd_addr_pkg::page_t   s1_page,    // Logical page
  input  nd_addr_pkg::offset_t s1_offset,  // Word offset
  input  logic                 s1_write,   // 1 = write
  input  logic                 s1_poni,    // Paging on
  input  nd_pte_pkg::pte_t     rd_entry,   // Entry for the held item
  output logic                 rsp_valid,  // Response present
  input  logic                 rsp_ready,  // Outside takes the response
  output nd_addr_pkg::paddr_t  rsp_paddr,  // Physical address
  output nd_pte_pkg::fault_t   rsp_fault   // Fault code
);

  nd_addr_pkg::ppn_t  ppn;                 // Chosen physical page
  nd_addr_pkg::ppn_t  lapa_ppn;            // Bypass page, paging off
  nd_pte_pkg::fault_t fault;               // Permit check result
  logic               wpm;
  logic               rpm;
  logic               take;                // Item moves in this edge

  // Permit bits of the entry
  assign wpm = rd_entry[nd_pte_pkg::PTE_WPM_BIT];
  assign rpm = rd_entry[nd_pte_pkg::PTE_RPM_BIT];

  // Old LAPA path, logical page zero-extended
  assign lapa_ppn = {{(nd_addr_pkg::PPN_W - nd_addr_pkg::PAGE_W){1'b0}}, s1_page};

  // PPN select
  always_comb begin
    if (s1_poni) begin
      ppn = rd_entry[nd_addr_pkg::PPN_W-1:0]; // From the page table
    end else begin
      ppn = lapa_ppn;
    end
  end

  // Permit check, only with paging on
  always_comb begin
    fault = nd_pte_pkg::FAULT_NONE;
    if (s1_poni) begin
      if (s1_write && !wpm) begin
        fault = nd_pte_pkg::FAULT_WRITE;   // Write-protected page
      end else if (!s1_write && !rpm) begin
        fault = nd_pte_pkg::FAULT_READ;    // Read-protected page
      end
    end
  end

  // No skid buffer, ready follows the output side
  assign s1_ready = !rsp_valid || rsp_ready;
  assign take     = s1_valid && s1_ready;

  always_ff @(posedge sysclk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else if (s1_ready) begin
      rsp_valid <= s1_valid;               // Load or drain the register
    end
  end

  // Response payload, held under back-pressure
  always_ff @(posedge sysclk) begin
    if (take) begin
      rsp_paddr <= {ppn, s1_offset};       // PPN 23:10, offset 9:0
      rsp_fault <= fault;
    end
  end

endmodule

// File: verilog/nd_addr_pkg.sv
// ND address package holding the logical and physical address formats
package nd_addr_pkg;

  localparam int PAGE_W   = 6;               // Logical page number width
  localparam int OFFSET_W = 10;              // Word offset within a page
  localparam int PPN_W    = 14;              // Physical page number, PPN 23:10

  localparam int VADDR_W  = PAGE_W + OFFSET_W; // 16-bit logical address
  localparam int PADDR_W  = PPN_W + OFFSET_W;  // 24-bit physical address

  localparam int PT_DEPTH = 1 << PAGE_W;     // One entry per logical page

  // Logical address, page above offset
  typedef logic [VADDR_W-1:0] vaddr_t;

  typedef logic [PAGE_W-1:0] page_t;         // Logical page number
  typedef logic [OFFSET_W-1:0] offset_t;     // Word offset

  typedef logic [PPN_W-1:0] ppn_t;           // Physical page number

  // Physical address, PPN above offset
  typedef logic [PADDR_W-1:0] paddr_t;

endpackage

// File: verilog/nd_pte_pkg.sv
// ND page table entry package with permit bits and fault codes
package nd_pte_pkg;

  localparam int PTE_W = 16;                 // Entry word, same width as IDB

  // Permit bit positions, PPN sits below them
  localparam int PTE_WPM_BIT = 15;           // Write permit
  localparam int PTE_RPM_BIT = 14;           // Read permit

  typedef logic [PTE_W-1:0] pte_t;           // Page table entry

  localparam int FAULT_W = 2;

  typedef logic [FAULT_W-1:0] fault_t;       // Fault code of a response

  // Fault codes
  localparam fault_t FAULT_NONE  = 2'd0;     // Access allowed
  localparam fault_t FAULT_READ  = 2'd1;     // Read without RPM
  localparam fault_t FAULT_WRITE = 2'd2;     // Write without WPM

endpackage
